// File: include/regex_consts.svh
`ifndef REGEX_CONSTS_SVH
`define REGEX_CONSTS_SVH

// apb port.
`define APB_ADDR_W   13
`define APB_DATA_W   32

// packet memory geometry.
`define LINE_W       128
`define LINE_BYTES   16
`define MEM_LINES    256
`define MEM_ADDR_W   8
`define BYTE_ADDR_W  12

// command fields.
`define LEN_W        16
`define PAT_MAX      4

// register map, byte offsets.
`define REG_CTRL     'h00
`define REG_LEN      'h04
`define REG_ADDR     'h08
`define REG_PAT      'h0C
`define REG_PCFG     'h10
`define MEM_BASE     'h1000

`endif

// File: src/regex_pkg.sv
`default_nettype none

`include "regex_consts.svh"

package regex_pkg;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`APB_ADDR_W-1:0]    paddr;
    logic [`APB_DATA_W-1:0]    pwdata;
    logic [`APB_DATA_W/8-1:0]  pstrb;
  } apb_req_t;

  typedef struct packed {
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

  // raw is what the host writes, bytes is what the matcher compares.
  typedef union packed {
    logic [`APB_DATA_W-1:0]    raw;
    logic [`PAT_MAX-1:0][7:0]  bytes; // byte 0 goes against the oldest byte.
  } pat_word_u;

  typedef struct packed {
    pat_word_u             word;
    logic [`PAT_MAX-1:0]   mask; // set bit means wildcard.
    logic [2:0]            len;  // 1 to 4.
  } pat_cfg_t;

  typedef struct packed {
    logic [`BYTE_ADDR_W-1:0] addr;
    logic [`LEN_W-1:0]       len;
    pat_cfg_t                pat;
  } cmd_t;

  typedef struct packed {
    logic                    en;
    logic [`MEM_ADDR_W-1:0]  addr;
    logic [`LINE_BYTES-1:0]  strb;
    logic [`LINE_W-1:0]      data;
  } mem_wr_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

  typedef struct packed {
    logic done;
    logic match;
  } result_t;

endpackage

`default_nettype wire

// File: src/packet_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_consts.svh"

module packet_mem
  import regex_pkg::*;
(
  input  wire                    clk,
  input  wire mem_wr_t           mem_wr,
  input  wire                    rd_en,
  input  wire [`MEM_ADDR_W-1:0]  rd_addr,
  output logic [`LINE_W-1:0]     rd_data
);

  logic [`LINE_W-1:0] mem [`MEM_LINES];

  // byte-strobed write port.
  always_ff @(posedge clk) begin
    if (mem_wr.en) begin
      for (int b = 0; b < `LINE_BYTES; b++) begin
        if (mem_wr.strb[b]) begin
          mem[mem_wr.addr][8*b +: 8] <= mem_wr.data[8*b +: 8];
        end
      end
    end
  end

  // read port, one cycle latency.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: src/pmem_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_consts.svh"

module pmem_fetch
  import regex_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    cmd_valid,
  output logic                   cmd_ready,
  input  wire cmd_t              cmd,
  output logic                   rd_en,
  output logic [`MEM_ADDR_W-1:0] rd_addr,
  input  wire  [`LINE_W-1:0]     rd_data,
  output logic                   start,
  output byte_beat_t             beat
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_READ  = 2'd1;
  localparam logic [1:0] ST_WAIT  = 2'd2;
  localparam logic [1:0] ST_SHIFT = 2'd3;

  logic [1:0]               state;
  logic [`BYTE_ADDR_W-1:0]  cur_addr;
  logic [`LEN_W-1:0]        rem;
  logic [`LINE_W-1:0]       line_buf;
  logic [`MEM_ADDR_W-1:0]   cur_line;
  logic [7:0]               cur_byte;
  logic                     line_end;

  assign cur_line = cur_addr[`BYTE_ADDR_W-1:4];
  assign cur_byte = line_buf[8*cur_addr[3:0] +: 8];
  assign line_end = (cur_addr[3:0] == 4'hf);

  // not ready while the last beat is still on its way to the matcher.
  assign cmd_ready = (state == ST_IDLE) && !beat.last;
  assign start     = cmd_valid && cmd_ready;

  // next line is fetched while the current line's last byte goes out.
  assign rd_en   = (state == ST_READ) || (state == ST_SHIFT && line_end && rem != 1);
  assign rd_addr = (state == ST_SHIFT) ? cur_line + 1'b1 : cur_line;

  always_ff @(posedge clk) begin
    beat.valid <= 1'b0;
    beat.last  <= 1'b0;

    case (state)
      ST_IDLE: begin
        if (start) begin
          cur_addr <= cmd.addr;
          rem      <= cmd.len;
          if (cmd.len == '0) begin
            beat.last <= 1'b1; // empty range, marker only.
          end else begin
            state <= ST_READ;
          end
        end
      end
      ST_READ: state <= ST_WAIT;
      ST_WAIT: begin
        line_buf <= rd_data;
        state    <= ST_SHIFT;
      end
      ST_SHIFT: begin
        beat.valid <= 1'b1;
        beat.data  <= cur_byte;
        beat.last  <= (rem == 1);
        cur_addr   <= cur_addr + 1'b1;
        rem        <= rem - 1'b1;
        if (rem == 1) begin
          state <= ST_IDLE;
        end else if (line_end) begin
          state <= ST_WAIT;
        end
      end
      default: state <= ST_IDLE;
    endcase

    if (rst) begin
      state      <= ST_IDLE;
      beat.valid <= 1'b0;
      beat.last  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/regex_match.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_consts.svh"

module regex_match
  import regex_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire             start,
  input  wire pat_cfg_t   pat,
  input  wire byte_beat_t beat,
  output result_t         result
);

  pat_cfg_t                  pat_q;
  logic [`PAT_MAX-1:0][7:0]  win;     // win[0] is the newest byte.
  logic [`PAT_MAX-1:0][7:0]  win_nxt;
  logic [2:0]                cnt;
  logic [2:0]                cnt_nxt;
  logic                      match_q;
  logic                      hit;
  logic [1:0]                pos;

  assign win_nxt = {win[`PAT_MAX-2:0], beat.data};
  assign cnt_nxt = (cnt == 3'd4) ? 3'd4 : cnt + 3'd1;

  // compare against the window as it will be after this beat.
  always_comb begin
    pos = 2'd0;
    hit = beat.valid && (cnt_nxt >= pat_q.len);
    for (int i = 0; i < `PAT_MAX; i++) begin
      if (i < pat_q.len) begin
        pos = 2'(pat_q.len - 3'(i) - 3'd1);
        if (!pat_q.mask[i] && win_nxt[pos] != pat_q.word.bytes[i]) begin
          hit = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      pat_q   <= pat; // pattern held for the whole run.
      cnt     <= 3'd0;
      match_q <= 1'b0;
    end else if (beat.valid) begin
      win     <= win_nxt;
      cnt     <= cnt_nxt;
      match_q <= match_q || hit;
    end

    result.done  <= beat.last;
    result.match <= match_q || hit;

    if (rst) begin
      cnt          <= 3'd0;
      match_q      <= 1'b0;
      result.done  <= 1'b0;
      result.match <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/accel_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_consts.svh"

module accel_regs
  import regex_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire apb_req_t apb_req,
  output apb_rsp_t      apb_rsp,
  output logic          cmd_valid,
  input  wire           cmd_ready,
  output cmd_t          cmd,
  input  wire result_t  result,
  output mem_wr_t       mem_wr
);

  logic                    access;
  logic                    wr_acc;
  logic                    in_window;
  logic                    is_reg;
  logic                    start_wr;
  logic                    handshake;
  logic                    status_done;
  logic                    status_match;
  logic [`APB_ADDR_W-1:0]  word_addr;
  logic [`APB_DATA_W-1:0]  rd_word;
  logic [2:0]              plen_wr;
  logic [1:0]              lane;

  // ==============================
  // apb decode
  // ==============================
  assign access    = apb_req.psel && apb_req.penable;
  assign wr_acc    = access && apb_req.pwrite;
  assign word_addr = {apb_req.paddr[`APB_ADDR_W-1:2], 2'b00};
  assign in_window = apb_req.paddr >= `APB_ADDR_W'(`MEM_BASE);
  assign lane      = apb_req.paddr[3:2];

  assign start_wr  = wr_acc && (word_addr == `REG_CTRL) &&
                     apb_req.pstrb[0] && apb_req.pwdata[0];
  assign handshake = cmd_valid && cmd_ready;

  // out-of-range pattern lengths fold to the maximum.
  assign plen_wr = (apb_req.pwdata[6:4] == 3'd0 || apb_req.pwdata[6:4] > 3'd4) ?
                   3'd4 : apb_req.pwdata[6:4];

  always_comb begin
    is_reg  = 1'b1;
    rd_word = '0;
    case (word_addr)
      `REG_CTRL: begin
        rd_word[1:0] = {cmd_ready, cmd_valid};
        rd_word[9:8] = {status_match, status_done};
      end
      `REG_LEN:  rd_word[`LEN_W-1:0]       = cmd.len;
      `REG_ADDR: rd_word[`BYTE_ADDR_W-1:0] = cmd.addr;
      `REG_PAT:  rd_word                   = cmd.pat.word.raw;
      `REG_PCFG: rd_word[6:0]              = {cmd.pat.len, cmd.pat.mask};
      default:   is_reg = 1'b0;
    endcase
  end

  assign apb_rsp.prdata  = (access && !apb_req.pwrite && is_reg) ? rd_word : '0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && !is_reg && !in_window;

  // ==============================
  // command and status
  // ==============================
  always_ff @(posedge clk) begin
    if (handshake) begin
      cmd_valid <= 1'b0;
    end else if (start_wr && cmd_ready) begin
      cmd_valid <= 1'b1; // starts while pending or running are dropped.
    end

    if (handshake) begin
      status_done  <= 1'b0;
      status_match <= 1'b0;
    end else if (result.done) begin
      status_done  <= 1'b1;
      status_match <= result.match;
    end

    // command fields hold still until the engine takes them.
    if (wr_acc && !cmd_valid) begin
      case (word_addr)
        `REG_LEN:  cmd.len           <= apb_req.pwdata[`LEN_W-1:0];
        `REG_ADDR: cmd.addr          <= apb_req.pwdata[`BYTE_ADDR_W-1:0];
        `REG_PAT:  cmd.pat.word.raw  <= apb_req.pwdata;
        `REG_PCFG: begin
          cmd.pat.mask <= apb_req.pwdata[3:0];
          cmd.pat.len  <= plen_wr;
        end
        default: ;
      endcase
    end

    if (rst) begin
      cmd_valid    <= 1'b0;
      status_done  <= 1'b0;
      status_match <= 1'b0;
      cmd.len      <= '0;
      cmd.addr     <= '0;
      cmd.pat.word <= '0;
      cmd.pat.mask <= '0;
      cmd.pat.len  <= 3'd4;
    end
  end

  // ==============================
  // memory window
  // ==============================
  always_comb begin
    mem_wr.en   = wr_acc && in_window;
    mem_wr.addr = apb_req.paddr[`MEM_ADDR_W+3:4];
    mem_wr.strb = `LINE_BYTES'(apb_req.pstrb) << {lane, 2'b00}; // 4 lanes per line.
    mem_wr.data = {(`LINE_W/`APB_DATA_W){apb_req.pwdata}};
  end

endmodule

`default_nettype wire

// File: src/regex_accel_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_consts.svh"

module regex_accel_top
  import regex_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire apb_req_t apb_req,
  output apb_rsp_t      apb_rsp
);

  logic                    cmd_valid;
  logic                    cmd_ready;
  cmd_t                    cmd;
  result_t                 result;
  mem_wr_t                 mem_wr;
  logic                    rd_en;
  logic [`MEM_ADDR_W-1:0]  rd_addr;
  logic [`LINE_W-1:0]      rd_data;
  logic                    start;
  byte_beat_t              beat;

  accel_regs regs_i (
    .clk       (clk),
    .rst       (rst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .result    (result),
    .mem_wr    (mem_wr)
  );

  packet_mem mem_i (
    .clk     (clk),
    .mem_wr  (mem_wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  pmem_fetch fetch_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .start     (start),
    .beat      (beat)
  );

  regex_match match_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .pat    (cmd.pat),
    .beat   (beat),
    .result (result)
  );

endmodule

`default_nettype wire

// File: verification/regex_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_consts.svh"

module regex_tb
  import regex_pkg::*;
();

  localparam int HALF = 20;
  localparam int MEM_BYTES = `MEM_LINES * `LINE_BYTES;

  logic        clk;
  logic        rst;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [7:0]  mirror [MEM_BYTES]; // byte image of the packet memory.
  logic [19:0] lfsr = 20'd99667;
  int          cycle_cnt = 0;

  regex_accel_top dut_i (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #HALF clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ==============================
  // random numbers and model
  // ==============================
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[19] ^ lfsr[16]; // x^20 + x^17 + 1.
      lfsr = {lfsr[18:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int norm_plen(input logic [2:0] p);
    return (p == 3'd0 || p > 3'd4) ? 4 : int'(p);
  endfunction

  // pattern byte i sits against stream byte j + i.
  function automatic result_t model_result(input logic [11:0] addr, input int len,
                                           input logic [31:0] pword, input logic [3:0] mask,
                                           input int plen);
    result_t r;
    logic    ok;
    r = 2'b10;
    for (int j = 0; j + plen <= len; j++) begin
      ok = 1'b1;
      for (int i = 0; i < plen; i++) begin
        if (!mask[i] && mirror[12'(addr + j + i)] != pword[8*i +: 8]) ok = 1'b0;
      end
      if (ok) r.match = 1'b1;
    end
    return r;
  endfunction

  function automatic apb_rsp_t make_rsp(input logic [31:0] data, input logic err);
    apb_rsp_t r;
    r.prdata  = data;
    r.pready  = 1'b1;
    r.pslverr = err;
    return r;
  endfunction

  // ==============================
  // checks
  // ==============================
  task automatic fail_run(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s gave rsp %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_result(input result_t got, input result_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s gave done/match %b, expected %b",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp));
    end
  endtask

  // ==============================
  // apb driver
  // ==============================
  task automatic bus_xfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                          input logic [31:0] data, input logic [3:0] strb,
                          output apb_rsp_t rsp);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wr ? data : '0;
    apb_req.pstrb   = wr ? strb : '0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #(HALF - 5); // late in the access cycle.
    rsp = apb_rsp;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic bus_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    apb_rsp_t rsp;
    bus_xfer(1'b1, addr, data, strb, rsp);
    check_rsp(rsp, make_rsp(32'h0, 1'b0), $sformatf("write to %h", addr));
  endtask

  task automatic bus_read(input logic [`APB_ADDR_W-1:0] addr, output apb_rsp_t rsp);
    bus_xfer(1'b0, addr, 32'h0, 4'h0, rsp);
  endtask

  task automatic reg_readback(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                              input logic [31:0] exp, input string what);
    apb_rsp_t rsp;
    bus_write(addr, data, 4'hf);
    bus_read(addr, rsp);
    check_word(rsp.prdata, exp, what);
  endtask

  task automatic mem_write(input int word, input logic [31:0] data, input logic [3:0] strb);
    bus_write(`APB_ADDR_W'(`MEM_BASE + 4 * word), data, strb);
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) mirror[4 * word + k] = data[8*k +: 8];
    end
  endtask

  task automatic wait_done(output logic [31:0] status);
    apb_rsp_t rsp;
    int       t0;
    t0     = cycle_cnt;
    status = '0;
    while (!status[8]) begin
      if (cycle_cnt - t0 > 2000) fail_run("done did not rise within 2000 cycles of the start");
      bus_read(`REG_CTRL, rsp);
      status = rsp.prdata;
    end
  endtask

  task automatic load_cmd(input logic [11:0] addr, input int len, input logic [31:0] pword,
                          input logic [3:0] mask, input logic [2:0] plen_raw);
    bus_write(`REG_LEN, 32'(len), 4'hf);
    bus_write(`REG_ADDR, 32'(addr), 4'hf);
    bus_write(`REG_PAT, pword, 4'hf);
    bus_write(`REG_PCFG, {25'd0, plen_raw, mask}, 4'hf);
    bus_write(`REG_CTRL, 32'h1, 4'hf);
  endtask

  task automatic run_cmd(input logic [11:0] addr, input int len, input logic [31:0] pword,
                         input logic [3:0] mask, input logic [2:0] plen_raw,
                         output result_t got);
    logic [31:0] status;
    load_cmd(addr, len, pword, mask, plen_raw);
    wait_done(status);
    got = result_t'({status[8], status[9]});
    check_result(got, model_result(addr, len, pword, mask, norm_plen(plen_raw)),
                 $sformatf("command at %h length %0d", addr, len));
  endtask

  // ==============================
  // scenario
  // ==============================
  initial begin
    apb_rsp_t    rsp;
    result_t     got;
    logic [31:0] status;
    logic [31:0] data;
    logic [31:0] pword;
    logic [11:0] addr;
    logic [3:0]  strb;
    logic [3:0]  mask;
    int          len;
    int          plen;
    int          ofs;
    rst     = 1'b1;
    apb_req = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    bus_read(`REG_CTRL, rsp);
    check_word(rsp.prdata, 32'h2, "status after reset");
    bus_read('h20, rsp);
    check_rsp(rsp, make_rsp(32'h0, 1'b1), "read of offset 0x20");
    bus_xfer(1'b1, 'h20, 32'h1, 4'hf, rsp);
    check_rsp(rsp, make_rsp(32'h0, 1'b1), "write to offset 0x20");
    bus_read(`MEM_BASE + 'h40, rsp);
    check_rsp(rsp, make_rsp(32'h0, 1'b0), "read of memory window");

    reg_readback(`REG_LEN, 32'h1234_abcd, 32'h0000_abcd, "length register");
    reg_readback(`REG_ADDR, 32'hffff_f5a3, 32'h0000_05a3, "address register");
    reg_readback(`REG_PAT, 32'hdead_beef, 32'hdead_beef, "pattern word");
    reg_readback(`REG_PCFG, 32'h05, 32'h45, "pattern length 0");
    reg_readback(`REG_PCFG, 32'h3a, 32'h3a, "pattern length 3");

    for (int w = 0; w < MEM_BYTES / 4; w++) begin
      data = rand_bits(32);
      mem_write(w, data, 4'hf);
    end
    for (int n = 0; n < 300; n++) begin
      ofs  = rand_bits(10);
      data = rand_bits(32);
      strb = rand_bits(4);
      mem_write(ofs, data, strb);
    end

    for (int n = 0; n < 40; n++) begin
      addr  = rand_bits(12);
      len   = rand_bits(7) % 65;
      plen  = rand_bits(2) + 1;
      mask  = rand_bits(4) & rand_bits(4);
      pword = rand_bits(32);
      if (rand_bits(1) && len >= plen) begin
        ofs = rand_bits(7) % (len - plen + 1); // copied pattern, sure to hit.
        for (int i = 0; i < plen; i++) pword[8*i +: 8] = mirror[12'(addr + ofs + i)];
      end
      run_cmd(addr, len, pword, mask, 3'(plen), got);
    end

    run_cmd(12'h0fb, 3, 32'h0, 4'hf, 3'd3, got);
    check_result(got, 2'b11, "wildcards, length equal to pattern");
    run_cmd(12'h0fb, 40, 32'h0, 4'hf, 3'd4, got);
    check_result(got, 2'b11, "wildcards across lines");
    run_cmd(12'h2c0, 2, 32'h0, 4'hf, 3'd3, got);
    check_result(got, 2'b10, "wildcards, range shorter than pattern");
    run_cmd(12'h123, 0, 32'h0, 4'hf, 3'd1, got);
    check_result(got, 2'b10, "empty range");

    // second start while busy.
    addr  = rand_bits(12);
    pword = {mirror[12'(addr + 7)], mirror[12'(addr + 6)],
             mirror[12'(addr + 5)], mirror[12'(addr + 4)]};
    load_cmd(addr, 64, pword, 4'h0, 3'd4);
    bus_write(`REG_CTRL, 32'h1, 4'hf);
    bus_read(`REG_CTRL, rsp);
    check_word(rsp.prdata, 32'h0, "status while busy after a second start");
    wait_done(status);
    check_result(result_t'({status[8], status[9]}), model_result(addr, 64, pword, 4'h0, 4),
                 "run with dropped start");
    check_word(status, 32'h302, "status after one run");
    bus_write(`REG_CTRL, 32'h1, 4'hf);
    bus_read(`REG_CTRL, rsp);
    check_word(rsp.prdata, 32'h0, "status once the next run is accepted");
    wait_done(status);
    check_word(status, 32'h302, "status after the next run");

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
src/regex_pkg.sv
src/packet_mem.sv
src/pmem_fetch.sv
src/regex_match.sv
src/accel_regs.sv
src/regex_accel_top.sv
verification/regex_tb.sv
